// ==== tilemapAddressGen.f ====
design/tilemapPkg.sv
design/videoTiming.sv
design/scrollRegisterDecode.sv
design/layerAddressGen.sv
design/addressInterleave.sv
design/tilemapAddressGen.sv
bench/clockGen.sv
bench/tilemapAddressGenTb.sv

// ==== Bender.yml ====
package:
  name: tilemapAddressGen

sources:
  - files:
      - design/tilemapPkg.sv
      - design/videoTiming.sv
      - design/scrollRegisterDecode.sv
      - design/layerAddressGen.sv
      - design/addressInterleave.sv
      - design/tilemapAddressGen.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/tilemapAddressGenTb.sv

// ==== bench/tilemapTrace.txt ====
// flip wAddr0 wData0 wAddr1 wData1 hPos vPos, all hex
// then expected ramAddr for codeA attrA codeB attrB; ffff ends the trace
0 0 2D 2 31 040 020 051A 051B 1210 1211
// X high bit on A, unused index ignored, 9-bit wrap
0 1 FF 3 FF 0F8 030 0608 0609 133E 133F
// Layer B low X and Y, layer A untouched
0 4 F0 6 80 100 041 070A 070B 1C7C 1C7D
0 5 01 7 00 020 050 0852 0853 1D04 1D05
// Column changes between code and attribute fetch
0 0 07 2 00 010 060 0644 0647 1E00 1E01
// Flipped
1 3 11 7 22 080 070 08A0 08A1 10DA 10DB
1 0 00 1 00 000 081 07FE 07FF 1FFA 1FFB
0 6 FF 4 08 178 090 095E 095F 18A0 18A1
1 2 C3 6 05 0A4 0C7 0FD6 0FD7 1398 1399
// vCount bit 8 plays no part
0 2 10 3 00 0C0 103 0130 0131 10F2 10F3
ffff

// ==== bench/tilemapAddressGenTb.sv ====
module tilemapAddressGenTb;
	timeunit 1ns;
	timeprecision 1ps;
	import tilemapPkg::*;

	localparam int clockPeriod = 100;
	localparam int lineCycles  = 384;
	localparam int frameLines  = 264;
	localparam int fieldCount  = 11;
	localparam int maxTests    = 32;
	localparam logic [15:0] endMarker = 16'hffff;

	// DUT ports
	logic                    clk6M;
	logic                    reset;
	logic                    hSyncN;
	logic                    vSyncN;
	logic                    flip;
	logic                    latchN;
	logic [2:0]              cpuAddr;
	logic [7:0]              cpuData;
	logic                    ramSelN;
	logic                    writeN;
	logic [7:0]              ramData;
	logic [ramAddrWidth-1:0] ramAddr;
	logic [gfxAddrWidth-1:0] gfxAddr;
	logic                    ramWriteN;
	logic                    ramReadN;
	logic [7:0]              ramDataOut;
	logic [7:0]              cpuDataOut;
	logic [2:0]              fineA;
	logic [2:0]              fineB;

	// Tile RAM, one 4 KiB bank per layer
	logic [7:0] tileRamA [4096];
	logic [7:0] tileRamB [4096];

	// Trace records, fieldCount words each
	logic [15:0] trace [maxTests*fieldCount];

	// Sync generator
	int dotCount;
	int lineCount;

	// Expected raster position
	logic [posWidth-1:0] hModel;
	logic [posWidth-1:0] vModel;
	logic                hSyncPrev;
	logic                vSyncPrev;

	// Scroll state as written by the CPU
	logic [8:0] scrollXA;
	logic [7:0] scrollYA;
	logic [8:0] scrollXB;
	logic [7:0] scrollYB;
	logic       flipOn;

	// Bookkeeping
	int   testCount;
	int   testsRun;
	int   checkCount;
	int   errorCount;
	logic traceOk;

	clockGen clocks (
		.clk   (clk6M),
		.reset (reset)
	);

	tilemapAddressGen UUT (
		.clk6M      (clk6M),
		.reset      (reset),
		.hSyncN     (hSyncN),
		.vSyncN     (vSyncN),
		.flip       (flip),
		.latchN     (latchN),
		.cpuAddr    (cpuAddr),
		.cpuData    (cpuData),
		.ramSelN    (ramSelN),
		.writeN     (writeN),
		.ramData    (ramData),
		.ramAddr    (ramAddr),
		.gfxAddr    (gfxAddr),
		.ramWriteN  (ramWriteN),
		.ramReadN   (ramReadN),
		.ramDataOut (ramDataOut),
		.cpuDataOut (cpuDataOut),
		.fineA      (fineA),
		.fineB      (fineB)
	);

	// Same-cycle RAM, top address bit picks the bank
	assign ramData = ramAddr[12] ? tileRamB[ramAddr[11:0]] : tileRamA[ramAddr[11:0]];

	////////////////////////////////////////////////////////////////////////////
	// Video sync and raster model
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk6M) begin
		if (reset) begin
			dotCount  <= 0;
			lineCount <= 0;
			hSyncN    <= 1'b1;
			vSyncN    <= 1'b1;
		end else begin
			if (dotCount == lineCycles - 1) begin
				dotCount  <= 0;
				lineCount <= (lineCount == frameLines - 1) ? 0 : lineCount + 1;
			end else begin
				dotCount <= dotCount + 1;
			end
			// One-cycle low pulses
			// vertical pulse lines up with the last horizontal one
			hSyncN <= (dotCount != lineCycles - 1);
			vSyncN <= !(dotCount == lineCycles - 1 && lineCount == frameLines - 1);
		end
	end

	// Counters by the sync edge rules
	always @(posedge clk6M) begin
		if (reset) begin
			hModel    <= '0;
			vModel    <= '0;
			hSyncPrev <= 1'b1;
			vSyncPrev <= 1'b1;
		end else begin
			hSyncPrev <= hSyncN;
			vSyncPrev <= vSyncN;
			if (hSyncPrev && !hSyncN) begin
				hModel <= '0;
			end else begin
				hModel <= hModel + 1'b1;
			end
			// Frame start wins over line advance
			if (vSyncPrev && !vSyncN) begin
				vModel <= '0;
			end else if (hSyncPrev && !hSyncN) begin
				vModel <= vModel + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, one bit per step
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end else begin
			return state >> 1;
		end
	endfunction

	// Horizontal tilemap position
	function automatic logic [8:0] scrolledX(input logic [8:0] hPos, input logic [8:0] scroll);
		logic [8:0] raster;
		raster = flipOn ? ~hPos : hPos;
		return raster + scroll;
	endfunction

	// Vertical tilemap position, low 8 raster bits only
	function automatic logic [7:0] scrolledY(input logic [8:0] vPos, input logic [7:0] scroll);
		logic [7:0] raster;
		raster = flipOn ? ~vPos[7:0] : vPos[7:0];
		return raster + scroll;
	endfunction

	// Both banks from one stream, bank A first
	task automatic fillTileRam();
		logic [31:0] state;
		logic [7:0]  value;
		state = 32'h8adc;
		for (int i = 0; i < 8192; i++) begin
			value = '0;
			for (int b = 0; b < 8; b++) begin
				state = lfsrStep(state);
				value = {value[6:0], state[0]};
			end
			if (i < 4096) begin
				tileRamA[i] = value;
			end else begin
				tileRamB[i - 4096] = value;
			end
		end
	endtask

	task automatic compareValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	task automatic reportTest(input string label, input int startErrors);
		testsRun++;
		if (errorCount == startErrors) begin
			$display("Test %s: ok", label);
		end else begin
			$display("Test %s: %0d mismatches", label, errorCount - startErrors);
		end
	endtask

	// One latch strobe, tracked register updated alongside
	task automatic scrollWrite(input logic [2:0] addr, input logic [7:0] data);
		@(posedge clk6M);
		latchN  <= 1'b0;
		cpuAddr <= addr;
		cpuData <= data;
		case (addr)
			3'd0: scrollXA[7:0] = data;
			3'd1: scrollXA[8] = data[0];
			3'd2: scrollYA = data;
			3'd4: scrollXB[7:0] = data;
			3'd5: scrollXB[8] = data[0];
			3'd6: scrollYB = data;
			default: begin
				// Index 3 on either layer holds nothing
			end
		endcase
		@(posedge clk6M);
		latchN <= 1'b1;
	endtask

	// Ends on the falling edge inside the target cycle
	task automatic waitPosition(input logic [8:0] h, input logic [8:0] v);
		@(negedge clk6M);
		while (hModel !== h || vModel !== v) begin
			@(negedge clk6M);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic checkReset();
		int startErrors;
		startErrors = errorCount;
		compareValue("ramAddr", ramAddr, '0);
		compareValue("gfxAddr", gfxAddr, '0);
		reportTest("reset", startErrors);
	endtask

	task automatic runTest(input int n);
		int          base;
		int          startErrors;
		logic [8:0]  h;
		logic [8:0]  v;
		logic [15:0] expAddr [4];
		logic [8:0]  xA;
		logic [8:0]  xB;
		logic [7:0]  yA;
		logic [7:0]  yB;
		base        = n * fieldCount;
		startErrors = errorCount;
		h           = trace[base + 5][8:0];
		v           = trace[base + 6][8:0];
		for (int k = 0; k < 4; k++) begin
			expAddr[k] = trace[base + 7 + k];
		end
		@(posedge clk6M);
		flip   <= trace[base][0];
		flipOn = trace[base][0];
		scrollWrite(trace[base + 1][2:0], trace[base + 2][7:0]);
		scrollWrite(trace[base + 3][2:0], trace[base + 4][7:0]);
		waitPosition(h, v);
		// Row within tile is the same through the slot
		yA = scrolledY(v, scrollYA);
		yB = scrolledY(v, scrollYB);
		for (int k = 0; k < 4; k++) begin
			if (k > 0) begin
				@(negedge clk6M);
			end
			compareValue($sformatf("ramAddr phase %0d", k), ramAddr, expAddr[k]);
			if (k == 0) begin
				xA = scrolledX(h, scrollXA);
				xB = scrolledX(h, scrollXB);
				compareValue("fineA", fineA, xA[2:0]);
				compareValue("fineB", fineB, xB[2:0]);
			end
			// Layer A shown in the second half of the slot
			if (k == 2) begin
				compareValue("gfxAddr layer A", gfxAddr, {tileRamA[expAddr[1][11:0]][2:0],
						tileRamA[expAddr[0][11:0]], yA[2:0]});
			end
		end
		// Layer B in the first half of the next slot
		@(negedge clk6M);
		compareValue("gfxAddr layer B", gfxAddr, {tileRamB[expAddr[3][11:0]][2:0],
				tileRamB[expAddr[2][11:0]], yB[2:0]});
		reportTest($sformatf("%0d h=0x%h v=0x%h flip=%0d", n + 1, h, v, flipOn), startErrors);
	endtask

	// All four select and write combinations
	task automatic checkCpuAccess();
		int         startErrors;
		logic [1:0] combo;
		logic       readOn;
		logic       writeOn;
		startErrors = errorCount;
		for (int c = 0; c < 4; c++) begin
			combo = c[1:0];
			@(posedge clk6M);
			ramSelN <= combo[1];
			writeN  <= combo[0];
			cpuData <= 8'hA0 | c[7:0];
			@(negedge clk6M);
			readOn  = !ramSelN && writeN;
			writeOn = !ramSelN && !writeN;
			compareValue("ramWriteN", ramWriteN, !writeOn);
			compareValue("ramReadN", ramReadN, !readOn);
			compareValue("ramDataOut", ramDataOut, cpuData);
			compareValue("cpuDataOut", cpuDataOut, readOn ? ramData : 8'h00);
		end
		@(posedge clk6M);
		ramSelN <= 1'b1;
		writeN  <= 1'b1;
		reportTest("cpu access", startErrors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		flip       = 1'b0;
		latchN     = 1'b1;
		cpuAddr    = '0;
		cpuData    = '0;
		ramSelN    = 1'b1;
		writeN     = 1'b1;
		hSyncN     = 1'b1;
		vSyncN     = 1'b1;
		scrollXA   = '0;
		scrollYA   = '0;
		scrollXB   = '0;
		scrollYB   = '0;
		flipOn     = 1'b0;
		testCount  = 0;
		testsRun   = 0;
		checkCount = 0;
		errorCount = 0;
		fillTileRam();
		$readmemh("bench/tilemapTrace.txt", trace);
		while (testCount < maxTests && trace[testCount * fieldCount] !== endMarker) begin
			testCount++;
		end
		traceOk = (testCount > 0 && testCount < maxTests);

		// First cycle out of reset
		@(negedge clk6M);
		while (reset) begin
			@(negedge clk6M);
		end
		checkReset();

		if (traceOk) begin
			for (int n = 0; n < testCount; n++) begin
				runTest(n);
			end
			checkCpuAccess();
		end else begin
			errorCount++;
			$display("Trace file missing, unreadable or without its end marker");
		end

		$display("Tests: %0d, checks: %0d, mismatches: %0d", testsRun, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// At most one frame of waiting per test, plus two frames of slack
	initial begin : watchdog
		longint limitNs;
		#1;
		limitNs = longint'(testCount + 2) * lineCycles * frameLines * clockPeriod;
		#(limitNs);
		$display("Timeout: raster position not reached after %0d ns", limitNs);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== bench/clockGen.sv ====
module clockGen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset over the first three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== design/tilemapAddressGen.sv ====
module tilemapAddressGen (
	input  logic                                clk6M,
	input  logic                                reset,
	input  logic                                hSyncN,
	input  logic                                vSyncN,
	input  logic                                flip,
	input  logic                                latchN,
	input  logic [2:0]                          cpuAddr,
	input  logic [7:0]                          cpuData,
	input  logic                                ramSelN,
	input  logic                                writeN,
	input  logic [7:0]                          ramData,
	output logic [tilemapPkg::ramAddrWidth-1:0] ramAddr,
	output logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddr,
	output logic                                ramWriteN,
	output logic                                ramReadN,
	output logic [7:0]                          ramDataOut,
	output logic [7:0]                          cpuDataOut,
	output logic [2:0]                          fineA,
	output logic [2:0]                          fineB
);
	import tilemapPkg::*;

	// Raster position
	logic [posWidth-1:0] hCount;
	logic [posWidth-1:0] vCount;

	// Scroll registers
	logic [8:0] scrollXA;
	logic [7:0] scrollYA;
	logic [8:0] scrollXB;
	logic [7:0] scrollYB;

	// Per-layer addresses
	logic [11:0]             ramAddrA;
	logic [11:0]             ramAddrB;
	logic [gfxAddrWidth-1:0] gfxAddrA;
	logic [gfxAddrWidth-1:0] gfxAddrB;

	videoTiming timing (
		.clk6M  (clk6M),
		.reset  (reset),
		.hSyncN (hSyncN),
		.vSyncN (vSyncN),
		.hCount (hCount),
		.vCount (vCount)
	);

	scrollRegisterDecode decode (
		.clk6M    (clk6M),
		.reset    (reset),
		.latchN   (latchN),
		.cpuAddr  (cpuAddr),
		.cpuData  (cpuData),
		.scrollXA (scrollXA),
		.scrollYA (scrollYA),
		.scrollXB (scrollXB),
		.scrollYB (scrollYB)
	);

	////////////////////////////////////////////////////////////////////////////
	// Two layers, same logic, different slot half
	////////////////////////////////////////////////////////////////////////////

	layerAddressGen layerA (
		.clk6M       (clk6M),
		.reset       (reset),
		.flip        (flip),
		.hCount      (hCount),
		.vCount      (vCount),
		.scrollX     (scrollXA),
		.scrollY     (scrollYA),
		.layerSelect (1'b0),
		.ramData     (ramData),
		.ramAddr     (ramAddrA),
		.gfxAddr     (gfxAddrA),
		.fine        (fineA)
	);

	layerAddressGen layerB (
		.clk6M       (clk6M),
		.reset       (reset),
		.flip        (flip),
		.hCount      (hCount),
		.vCount      (vCount),
		.scrollX     (scrollXB),
		.scrollY     (scrollYB),
		.layerSelect (1'b1),
		.ramData     (ramData),
		.ramAddr     (ramAddrB),
		.gfxAddr     (gfxAddrB),
		.fine        (fineB)
	);

	// Shared buses and CPU gating
	addressInterleave interleave (
		.hCount     (hCount),
		.ramAddrA   (ramAddrA),
		.ramAddrB   (ramAddrB),
		.gfxAddrA   (gfxAddrA),
		.gfxAddrB   (gfxAddrB),
		.ramSelN    (ramSelN),
		.writeN     (writeN),
		.cpuData    (cpuData),
		.ramData    (ramData),
		.ramAddr    (ramAddr),
		.gfxAddr    (gfxAddr),
		.ramWriteN  (ramWriteN),
		.ramReadN   (ramReadN),
		.ramDataOut (ramDataOut),
		.cpuDataOut (cpuDataOut)
	);

endmodule

// ==== design/addressInterleave.sv ====
module addressInterleave (
	input  logic [tilemapPkg::posWidth-1:0]     hCount,
	input  logic [11:0]                         ramAddrA,
	input  logic [11:0]                         ramAddrB,
	input  logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddrA,
	input  logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddrB,
	input  logic                                ramSelN,
	input  logic                                writeN,
	input  logic [7:0]                          cpuData,
	input  logic [7:0]                          ramData,
	output logic [tilemapPkg::ramAddrWidth-1:0] ramAddr,
	output logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddr,
	output logic                                ramWriteN,
	output logic                                ramReadN,
	output logic [7:0]                          ramDataOut,
	output logic [7:0]                          cpuDataOut
);
	import tilemapPkg::*;

	// Current clock of the fetch slot
	fetchPhase phase;

	assign phase = fetchPhase'(hCount[1:0]);

	////////////////////////////////////////////////////////////////////////////
	// Tile RAM address bus
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		unique case (phase)
			// Layer A half, leading 0
			phaseCodeA, phaseAttrA: ramAddr = {1'b0, ramAddrA};
			// Layer B half, leading 1
			phaseCodeB, phaseAttrB: ramAddr = {1'b1, ramAddrB};
		endcase
	end

	// ROM side runs half a slot behind the RAM side
	// A shows while B fetches and the other way round
	assign gfxAddr = hCount[1] ? gfxAddrA : gfxAddrB;

	////////////////////////////////////////////////////////////////////////////
	// CPU access to tile RAM
	////////////////////////////////////////////////////////////////////////////

	// Both strobes idle high while unselected
	assign ramWriteN = ramSelN | writeN;
	assign ramReadN  = ramSelN | ~writeN;

	// Write data always presented
	assign ramDataOut = cpuData;

	// Read data only during a selected read
	assign cpuDataOut = ramReadN ? 8'h00 : ramData;

endmodule

// ==== design/layerAddressGen.sv ====
module layerAddressGen (
	input  logic                                clk6M,
	input  logic                                reset,
	input  logic                                flip,
	input  logic [tilemapPkg::posWidth-1:0]     hCount,
	input  logic [tilemapPkg::posWidth-1:0]     vCount,
	input  logic [8:0]                          scrollX,
	input  logic [7:0]                          scrollY,
	input  logic                                layerSelect,
	input  logic [7:0]                          ramData,
	output logic [11:0]                         ramAddr,
	output logic [tilemapPkg::gfxAddrWidth-1:0] gfxAddr,
	output logic [2:0]                          fine
);
	import tilemapPkg::*;

	// Raster position after optional flip
	logic [posWidth-1:0] rasterX;
	logic [7:0]          rasterY;

	// Position in the scrolled tilemap
	logic [posWidth-1:0] tileX;
	logic [7:0]          tileY;

	// Slot decode for this layer
	logic ownSlot;
	logic codePhase;
	logic attrPhase;

	// Code byte held until the attribute arrives
	logic [7:0] codeByte;

	////////////////////////////////////////////////////////////////////////////
	// Scrolled position
	////////////////////////////////////////////////////////////////////////////

	// Flip mirrors both axes before scroll is added
	assign rasterX = flip ? ~hCount : hCount;
	assign rasterY = flip ? ~vCount[7:0] : vCount[7:0];

	// Both sums wrap at their own width
	assign tileX = rasterX + scrollX;
	assign tileY = rasterY + scrollY;

	// Pixel within the tile
	assign fine = tileX[2:0];

	////////////////////////////////////////////////////////////////////////////
	// Tile RAM address
	////////////////////////////////////////////////////////////////////////////

	// Layer A owns the first half of the slot, B the second
	assign ownSlot   = (hCount[1] == layerSelect);
	assign codePhase = ownSlot & ~hCount[0];
	assign attrPhase = ownSlot & hCount[0];

	// Row, column, then byte select
	// hCount[0] low reads code, high reads attribute
	assign ramAddr = {tileY[7:3], tileX[8:3], hCount[0]};

	////////////////////////////////////////////////////////////////////////////
	// Tile data capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M) begin
		if (reset) begin
			codeByte <= '0;
			gfxAddr  <= '0;
		end else begin
			// End of code phase
			if (codePhase) begin
				codeByte <= ramData;
			end
			// End of attribute phase, attribute taken straight off the RAM
			// Row within tile as it stands at this edge
			if (attrPhase) begin
				gfxAddr <= {ramData[2:0], codeByte, tileY[2:0]};
			end
		end
	end

endmodule

// ==== design/scrollRegisterDecode.sv ====
module scrollRegisterDecode (
	input  logic       clk6M,
	input  logic       reset,
	input  logic       latchN,
	input  logic [2:0] cpuAddr,
	input  logic [7:0] cpuData,
	output logic [8:0] scrollXA,
	output logic [7:0] scrollYA,
	output logic [8:0] scrollXB,
	output logic [7:0] scrollYB
);
	import tilemapPkg::*;

	// Scroll state, index 0 is layer A, index 1 is layer B
	logic [8:0] scrollX [2];
	logic [7:0] scrollY [2];

	// Decoded write target
	logic     layer;
	scrollReg regSel;

	// Bit 2 picks the layer, low bits pick the register
	assign layer  = cpuAddr[2];
	assign regSel = scrollReg'(cpuAddr[1:0]);

	////////////////////////////////////////////////////////////////////////////
	// Register writes on the latch strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M) begin
		if (reset) begin
			for (int i = 0; i < 2; i++) begin
				scrollX[i] <= '0;
				scrollY[i] <= '0;
			end
		end else if (!latchN) begin
			// One-cycle strobe, no back-pressure
			unique case (regSel)
				regScrollXLow: begin
					scrollX[layer][7:0] <= cpuData;
				end
				regScrollXHigh: begin
					// Only the ninth bit lives here
					scrollX[layer][8] <= cpuData[0];
				end
				regScrollY: begin
					scrollY[layer] <= cpuData;
				end
				regUnused: begin
					// Nothing to update
				end
			endcase
		end
	end

	// Per-layer outputs
	assign scrollXA = scrollX[0];
	assign scrollYA = scrollY[0];
	assign scrollXB = scrollX[1];
	assign scrollYB = scrollY[1];

endmodule

// ==== design/videoTiming.sv ====
module videoTiming (
	input  logic                            clk6M,
	input  logic                            reset,
	input  logic                            hSyncN,
	input  logic                            vSyncN,
	output logic [tilemapPkg::posWidth-1:0] hCount,
	output logic [tilemapPkg::posWidth-1:0] vCount
);

	// Previous sync samples
	logic hSyncLast;
	logic vSyncLast;

	// Falling edge seen this cycle
	logic hSyncFall;
	logic vSyncFall;

	////////////////////////////////////////////////////////////////////////////
	// Sync edge detect
	////////////////////////////////////////////////////////////////////////////

	// High last cycle, low now
	assign hSyncFall = hSyncLast & ~hSyncN;
	assign vSyncFall = vSyncLast & ~vSyncN;

	// Cleared to low, so a sync held low through reset gives no edge
	always_ff @(posedge clk6M) begin
		if (reset) begin
			hSyncLast <= 1'b0;
			vSyncLast <= 1'b0;
		end else begin
			hSyncLast <= hSyncN;
			vSyncLast <= vSyncN;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			// Horizontal restarts on each line
			if (hSyncFall) begin
				hCount <= '0;
			end else begin
				hCount <= hCount + 1'b1;
			end

			// Frame start takes priority over line advance
			if (vSyncFall) begin
				vCount <= '0;
			end else if (hSyncFall) begin
				vCount <= vCount + 1'b1;
			end
		end
	end

endmodule

// ==== design/tilemapPkg.sv ====
package tilemapPkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////////////////////

	// Raster counters, 9 bits each
	localparam int posWidth = 9;

	// Tile RAM address, top bit picks the layer
	localparam int ramAddrWidth = 13;

	// Graphics ROM address
	localparam int gfxAddrWidth = 14;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// CPU register index on cpuAddr[1:0]
	typedef enum logic [1:0] {
		regScrollXLow  = 2'd0, // X scroll bits 7..0
		regScrollXHigh = 2'd1, // Data bit 0 into X scroll bit 8
		regScrollY     = 2'd2, // Full 8-bit Y scroll
		regUnused      = 2'd3  // Writes dropped
	} scrollReg;

	// Clock within a four-clock fetch slot, from hCount[1:0]
	typedef enum logic [1:0] {
		phaseCodeA = 2'd0,
		phaseAttrA = 2'd1,
		phaseCodeB = 2'd2,
		phaseAttrB = 2'd3
	} fetchPhase;

endpackage
